// File: common/corr_pkg.sv
/* correlator shared definitions */

package corr_pkg;

	// input lines and line pairs
	localparam int NUM_LINES = 4;
	localparam int NUM_BASELINES = NUM_LINES * (NUM_LINES - 1) / 2;

	// counters wrap without saturation
	localparam int COUNT_W = 16;

	typedef logic [COUNT_W-1:0] count_t;
	typedef logic [NUM_LINES-1:0] line_mask_t;
	typedef logic [7:0] byte_t;
	typedef logic [3:0] opcode_t;

	// flat count vectors with entry i at [i*COUNT_W +: COUNT_W]
	typedef logic [NUM_LINES*COUNT_W-1:0] line_counts_t;
	typedef logic [NUM_BASELINES*COUNT_W-1:0] pair_counts_t;

	// opcode sits in the upper nibble of a command byte
	localparam opcode_t CMD_MASK = 4'h1;
	localparam opcode_t CMD_START = 4'h2;
	localparam opcode_t CMD_STOP = 4'h3;

	// baseline order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
	localparam int BASE_A [NUM_BASELINES] = '{0, 0, 0, 1, 1, 2};
	localparam int BASE_B [NUM_BASELINES] = '{1, 2, 3, 2, 3, 3};

	// packet layout
	localparam byte_t PKT_SYNC = 8'hA5;
	localparam int PKT_BYTES = 23;
	localparam int PAYLOAD_W = (NUM_LINES + NUM_BASELINES) * COUNT_W;

	typedef logic [$clog2(PKT_BYTES)-1:0] pkt_idx_t;

	localparam pkt_idx_t PKT_SYNC_IDX = pkt_idx_t'(0);
	localparam pkt_idx_t PKT_NLINES_IDX = pkt_idx_t'(1);
	localparam pkt_idx_t PKT_CSUM_IDX = pkt_idx_t'(PKT_BYTES - 1);  // last byte
	localparam byte_t PKT_NLINES = byte_t'(NUM_LINES);

endpackage

// File: logic/line_conditioner.sv
/* input line conditioner */

module line_conditioner (
	input  logic                 intclk,
	input  logic                 rst_n,
	input  corr_pkg::line_mask_t line_in,
	input  corr_pkg::line_mask_t invert_mask,
	output corr_pkg::line_mask_t pulses
);

	corr_pkg::line_mask_t meta_q;   // first sync stage that may go metastable
	corr_pkg::line_mask_t sync_q;
	corr_pkg::line_mask_t level;
	corr_pkg::line_mask_t level_q;

	// inversion after the synchronizer so a mask change acts like a line edge
	assign level = sync_q ^ invert_mask;

	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			meta_q <= '0;
			sync_q <= '0;
			level_q <= '0;
			pulses <= '0;
		end else begin
			meta_q <= line_in;
			sync_q <= meta_q;
			level_q <= level;
			pulses <= level & ~level_q;   // one cycle per rising edge
		end
	end

endmodule

// File: correlator/pulse_counter.sv
/* per-line pulse counter */

module pulse_counter (
	input  logic                   intclk,
	input  logic                   rst_n,
	input  corr_pkg::line_mask_t   pulses,
	input  logic                   clear,
	input  logic                   integrating,
	output corr_pkg::line_counts_t line_counts
);

	corr_pkg::count_t cnt [corr_pkg::NUM_LINES];

	always_ff @(posedge intclk) begin
		for (int i = 0; i < corr_pkg::NUM_LINES; i++) begin
			if (!rst_n) begin
				cnt[i] <= '0;
			end else if (clear) begin
				cnt[i] <= '0;
			end else if (integrating && pulses[i]) begin
				cnt[i] <= cnt[i] + 1'b1;   // wraps at 2^16
			end
		end
	end

	// line 0 in the low bits
	always_comb begin
		for (int i = 0; i < corr_pkg::NUM_LINES; i++) begin
			line_counts[i*corr_pkg::COUNT_W +: corr_pkg::COUNT_W] = cnt[i];
		end
	end

endmodule

// File: correlator/coincidence_counter.sv
/* zero-lag coincidence counter */

module coincidence_counter (
	input  logic                   intclk,
	input  logic                   rst_n,
	input  corr_pkg::line_mask_t   pulses,
	input  logic                   clear,
	input  logic                   integrating,
	output corr_pkg::pair_counts_t pair_counts
);

	corr_pkg::count_t cnt [corr_pkg::NUM_BASELINES];
	logic [corr_pkg::NUM_BASELINES-1:0] hits;

	// both lines of a pair pulsing in the same cycle
	always_comb begin
		for (int b = 0; b < corr_pkg::NUM_BASELINES; b++) begin
			hits[b] = pulses[corr_pkg::BASE_A[b]] & pulses[corr_pkg::BASE_B[b]];
		end
	end

	always_ff @(posedge intclk) begin
		for (int b = 0; b < corr_pkg::NUM_BASELINES; b++) begin
			if (!rst_n) begin
				cnt[b] <= '0;
			end else if (clear) begin
				cnt[b] <= '0;
			end else if (integrating && hits[b]) begin
				cnt[b] <= cnt[b] + 1'b1;
			end
		end
	end

	// baseline 0 in the low bits in package table order
	always_comb begin
		for (int b = 0; b < corr_pkg::NUM_BASELINES; b++) begin
			pair_counts[b*corr_pkg::COUNT_W +: corr_pkg::COUNT_W] = cnt[b];
		end
	end

endmodule

// File: logic/cmd_parser.sv
/* command byte decoder */

module cmd_parser (
	input  logic                 intclk,
	input  logic                 rst_n,
	input  corr_pkg::byte_t      rx_byte,
	input  logic                 rx_valid,
	input  logic                 busy,
	output corr_pkg::line_mask_t invert_mask,
	output logic                 clear,
	output logic                 integrating,
	output logic                 send
);

	corr_pkg::opcode_t opcode;
	corr_pkg::line_mask_t operand;

	assign opcode = rx_byte[7:4];
	assign operand = rx_byte[corr_pkg::NUM_LINES-1:0];

	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			invert_mask <= '0;
			clear <= 1'b0;
			integrating <= 1'b0;
			send <= 1'b0;
		end else begin
			// strobes last one cycle
			clear <= 1'b0;
			send <= 1'b0;
			if (rx_valid) begin
				case (opcode)
					corr_pkg::CMD_MASK: begin
						invert_mask <= operand;
					end
					corr_pkg::CMD_START: begin
						// a restart while integrating also clears
						if (!busy) begin
							clear <= 1'b1;
							integrating <= 1'b1;
						end
					end
					corr_pkg::CMD_STOP: begin
						if (integrating) begin
							integrating <= 1'b0;
							send <= 1'b1;
						end
					end
					default: begin
						// unknown opcodes dropped
					end
				endcase
			end
		end
	end

endmodule

// File: logic/packet_tx.sv
/* count packet transmitter */

module packet_tx (
	input  logic                   intclk,
	input  logic                   rst_n,
	input  logic                   send,
	input  corr_pkg::line_counts_t line_counts,
	input  corr_pkg::pair_counts_t pair_counts,
	input  logic                   tx_next,
	output corr_pkg::byte_t        tx_byte,
	output logic                   tx_valid,
	output logic                   busy
);

	typedef enum logic {
		IDLE,
		SENDING
	} state_t;

	state_t state;
	corr_pkg::pkt_idx_t idx;
	logic [corr_pkg::PAYLOAD_W-1:0] snap;     // next payload byte in the top bits
	logic [corr_pkg::PAYLOAD_W-1:0] snap_d;
	corr_pkg::byte_t csum;
	logic start;
	logic consume;
	logic in_payload;

	assign start = send && (state == IDLE);
	assign consume = tx_next && (state == SENDING);
	assign in_payload = (idx > corr_pkg::PKT_NLINES_IDX) && (idx < corr_pkg::PKT_CSUM_IDX);

	assign tx_valid = (state == SENDING);
	assign busy = (state == SENDING);

	// line counts first and then baselines with each count MSB first
	always_comb begin
		for (int i = 0; i < corr_pkg::NUM_LINES; i++) begin
			snap_d[corr_pkg::PAYLOAD_W-(i+1)*corr_pkg::COUNT_W +: corr_pkg::COUNT_W] =
				line_counts[i*corr_pkg::COUNT_W +: corr_pkg::COUNT_W];
		end
		for (int b = 0; b < corr_pkg::NUM_BASELINES; b++) begin
			snap_d[corr_pkg::PAYLOAD_W-(corr_pkg::NUM_LINES+b+1)*corr_pkg::COUNT_W +:
				corr_pkg::COUNT_W] = pair_counts[b*corr_pkg::COUNT_W +: corr_pkg::COUNT_W];
		end
	end

	always_comb begin
		case (idx)
			corr_pkg::PKT_SYNC_IDX:   tx_byte = corr_pkg::PKT_SYNC;
			corr_pkg::PKT_NLINES_IDX: tx_byte = corr_pkg::PKT_NLINES;
			corr_pkg::PKT_CSUM_IDX:   tx_byte = csum;
			default:                  tx_byte = snap[corr_pkg::PAYLOAD_W-1 -: 8];
		endcase
	end

	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			state <= IDLE;
			idx <= '0;
		end else if (start) begin
			state <= SENDING;
			idx <= '0;
		end else if (consume) begin
			if (idx == corr_pkg::PKT_CSUM_IDX) begin
				state <= IDLE;
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// snapshot and running checksum
	always_ff @(posedge intclk) begin
		if (start) begin
			snap <= snap_d;
			csum <= '0;
		end else if (consume) begin
			csum <= csum ^ tx_byte;
			if (in_payload)
				snap <= snap << 8;
		end
	end

endmodule

// File: logic/corr_top.sv
/* correlator acquisition core */

module corr_top (
	input  logic                 intclk,
	input  logic                 rst_n,
	input  corr_pkg::line_mask_t line_in,
	input  corr_pkg::byte_t      rx_byte,
	input  logic                 rx_valid,
	input  logic                 tx_next,
	output corr_pkg::byte_t      tx_byte,
	output logic                 tx_valid,
	output logic                 integrating,
	output logic                 busy
);

	corr_pkg::line_mask_t pulses;
	corr_pkg::line_mask_t invert_mask;
	corr_pkg::line_counts_t line_counts;
	corr_pkg::pair_counts_t pair_counts;
	logic clear;
	logic send;

	line_conditioner cond0 (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.line_in     (line_in),
		.invert_mask (invert_mask),
		.pulses      (pulses)
	);

	pulse_counter pcnt0 (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.pulses      (pulses),
		.clear       (clear),
		.integrating (integrating),
		.line_counts (line_counts)
	);

	coincidence_counter ccnt0 (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.pulses      (pulses),
		.clear       (clear),
		.integrating (integrating),
		.pair_counts (pair_counts)
	);

	cmd_parser parser0 (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.rx_byte     (rx_byte),
		.rx_valid    (rx_valid),
		.busy        (busy),
		.invert_mask (invert_mask),
		.clear       (clear),
		.integrating (integrating),
		.send        (send)
	);

	packet_tx tx0 (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.send        (send),
		.line_counts (line_counts),
		.pair_counts (pair_counts),
		.tx_next     (tx_next),
		.tx_byte     (tx_byte),
		.tx_valid    (tx_valid),
		.busy        (busy)
	);

endmodule

// File: tb/tb_clock.sv
/* testbench clock and reset */

module tb_clock (
	output logic intclk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		intclk = 1'b0;
		forever #10 intclk = ~intclk;   // 20 ns period
	end

	// reset held for 8 rising edges and released between edges
	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge intclk);
		@(negedge intclk);
		rst_n = 1'b1;
	end

endmodule

// File: tb/corr_tb.sv
/* correlator core testbench */

module corr_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CYCLE_LIMIT = 20000;

	logic intclk;
	logic rst_n;
	corr_pkg::line_mask_t line_in;
	corr_pkg::byte_t rx_byte;
	logic rx_valid;
	logic tx_next;
	corr_pkg::byte_t tx_byte;
	logic tx_valid;
	logic integrating;
	logic busy;

	// reference model state
	int exp_line [corr_pkg::NUM_LINES];
	int exp_pair [corr_pkg::NUM_BASELINES];
	corr_pkg::byte_t exp_pkt [corr_pkg::PKT_BYTES];
	corr_pkg::line_mask_t cur_lines;
	corr_pkg::line_mask_t model_mask;
	bit model_int;
	int cycle_count;

	tb_clock clk0 (
		.intclk (intclk),
		.rst_n  (rst_n)
	);

	corr_top dut0 (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.line_in     (line_in),
		.rx_byte     (rx_byte),
		.rx_valid    (rx_valid),
		.tx_next     (tx_next),
		.tx_byte     (tx_byte),
		.tx_valid    (tx_valid),
		.integrating (integrating),
		.busy        (busy)
	);

	task automatic fail_run();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input int got, input int exp);
		$display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
		fail_run();
	endtask

	// status levels and byte hold under back-pressure
	assert property (@(posedge intclk) disable iff (!rst_n) tx_valid == busy)
		else value_error("busy", $sampled(busy), $sampled(tx_valid));
	assert property (@(posedge intclk) disable iff (!rst_n) busy |-> !integrating)
		else value_error("integrating", $sampled(integrating), 0);
	assert property (@(posedge intclk) disable iff (!rst_n)
		tx_valid && !tx_next |=> $stable(tx_byte))
		else value_error("tx_byte", $sampled(tx_byte), $past(tx_byte));

	always @(posedge intclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			fail_run();
		end
	end

	// drive the lines and count the edges of (line ^ mask)
	task automatic set_lines(input corr_pkg::line_mask_t v, input int hold);
		corr_pkg::line_mask_t rising;
		rising = (v ^ model_mask) & ~(cur_lines ^ model_mask);
		if (model_int) begin
			for (int i = 0; i < corr_pkg::NUM_LINES; i++) begin
				if (rising[i])
					exp_line[i]++;
			end
			for (int b = 0; b < corr_pkg::NUM_BASELINES; b++) begin
				if (rising[corr_pkg::BASE_A[b]] && rising[corr_pkg::BASE_B[b]])
					exp_pair[b]++;
			end
		end
		line_in = v;
		cur_lines = v;
		repeat (hold) @(negedge intclk);
	endtask

	task automatic pulse(input corr_pkg::line_mask_t m);
		set_lines(m, 4);
		set_lines('0, 4);
	endtask

	// two lines rising two cycles apart
	task automatic stagger(input int a, input int b);
		set_lines(corr_pkg::line_mask_t'(1 << a), 2);
		set_lines(corr_pkg::line_mask_t'((1 << a) | (1 << b)), 4);
		set_lines('0, 4);
	endtask

	task automatic send_cmd(input corr_pkg::byte_t b);
		rx_byte = b;
		rx_valid = 1'b1;
		@(negedge intclk);
		rx_valid = 1'b0;
		rx_byte = '0;
	endtask

	task automatic set_mask(input corr_pkg::line_mask_t m);
		send_cmd({corr_pkg::CMD_MASK, m});
		model_mask = m;
		repeat (6) @(negedge intclk);   // mask edge drains while idle
	endtask

	task automatic do_start();
		send_cmd({corr_pkg::CMD_START, 4'h0});
		for (int i = 0; i < corr_pkg::NUM_LINES; i++)
			exp_line[i] = 0;
		for (int b = 0; b < corr_pkg::NUM_BASELINES; b++)
			exp_pair[b] = 0;
		model_int = 1'b1;
		assert (integrating) else value_error("integrating", integrating, 1);
		repeat (2) @(negedge intclk);
	endtask

	task automatic build_expected();
		corr_pkg::byte_t x;
		int k;
		exp_pkt[0] = 8'hA5;
		exp_pkt[1] = 8'd4;
		k = 2;
		for (int i = 0; i < corr_pkg::NUM_LINES; i++) begin
			exp_pkt[k] = corr_pkg::byte_t'(exp_line[i] >> 8);
			exp_pkt[k+1] = corr_pkg::byte_t'(exp_line[i]);
			k += 2;
		end
		for (int b = 0; b < corr_pkg::NUM_BASELINES; b++) begin
			exp_pkt[k] = corr_pkg::byte_t'(exp_pair[b] >> 8);
			exp_pkt[k+1] = corr_pkg::byte_t'(exp_pair[b]);
			k += 2;
		end
		x = '0;
		for (int j = 0; j < k; j++)
			x ^= exp_pkt[j];
		exp_pkt[k] = x;
	endtask

	// stop integration and wait for the first packet byte
	task automatic stop_and_wait();
		int n;
		repeat (6) @(negedge intclk);   // last edges through the pipeline
		send_cmd({corr_pkg::CMD_STOP, 4'h0});
		model_int = 1'b0;
		assert (!integrating) else value_error("integrating", integrating, 0);
		build_expected();
		n = 0;
		while (!tx_valid) begin
			if (n > 50) begin
				$display("No packet appeared after the stop command");
				fail_run();
			end
			@(negedge intclk);
			n++;
		end
	endtask

	task automatic check_byte(input int i);
		assert (tx_valid) else value_error("tx_valid", tx_valid, 1);
		assert (tx_byte == exp_pkt[i]) else value_error("tx_byte", tx_byte, exp_pkt[i]);
	endtask

	task automatic read_packet();
		corr_pkg::byte_t xsum;
		int gap;
		xsum = '0;
		for (int i = 0; i < corr_pkg::PKT_BYTES; i++) begin
			gap = $urandom_range(0, 7);
			for (int g = 0; g < gap; g++) begin
				check_byte(i);
				@(negedge intclk);
			end
			check_byte(i);
			if (i == corr_pkg::PKT_BYTES - 1)
				assert (tx_byte == xsum) else value_error("checksum", tx_byte, xsum);
			xsum ^= tx_byte;
			tx_next = 1'b1;
			@(negedge intclk);
			tx_next = 1'b0;
		end
		assert (!tx_valid) else value_error("tx_valid", tx_valid, 0);
		assert (!busy) else value_error("busy", busy, 0);
	endtask

	task automatic do_stop();
		stop_and_wait();
		read_packet();
	endtask

	initial begin
		line_in = '0;
		rx_byte = '0;
		rx_valid = 1'b0;
		tx_next = 1'b0;
		cur_lines = '0;
		model_mask = '0;
		model_int = 1'b0;
		cycle_count = 0;
		void'($urandom(51));
		@(posedge rst_n);
		@(negedge intclk);

		// reset state and a stray consume pulse
		assert (!integrating) else value_error("integrating", integrating, 0);
		assert (!busy) else value_error("busy", busy, 0);
		assert (!tx_valid) else value_error("tx_valid", tx_valid, 0);
		tx_next = 1'b1;
		@(negedge intclk);
		tx_next = 1'b0;
		repeat (4) begin
			@(negedge intclk);
			assert (!tx_valid) else value_error("tx_valid", tx_valid, 0);
		end

		// per-line counts
		do_start();
		for (int i = 0; i < corr_pkg::NUM_LINES; i++) begin
			repeat ($urandom_range(1, 8)) pulse(corr_pkg::line_mask_t'(1 << i));
		end
		do_stop();

		// coincidences with a start sent while the packet is in flight
		do_start();
		repeat (3) pulse(4'b0011);
		repeat (2) pulse(4'b1100);
		pulse(4'b0101);
		stagger(1, 2);
		stagger(0, 3);
		stop_and_wait();
		fork
			read_packet();
			begin
				repeat (10) @(negedge intclk);
				send_cmd({corr_pkg::CMD_START, 4'h0});
			end
		join
		assert (!integrating) else value_error("integrating", integrating, 0);

		// stop while idle gives no packet
		send_cmd({corr_pkg::CMD_STOP, 4'h0});
		repeat (40) begin
			@(negedge intclk);
			assert (!tx_valid) else value_error("tx_valid", tx_valid, 0);
		end

		// inversion makes masked lines count falling edges of line_in
		set_mask(4'b0101);
		do_start();
		for (int i = 0; i < corr_pkg::NUM_LINES; i++) begin
			repeat ($urandom_range(1, 6)) pulse(corr_pkg::line_mask_t'(1 << i));
		end
		set_lines(4'b0111, 4);   // only line 1 counts this one
		do_stop();
		set_lines('0, 4);
		set_mask(4'b0000);

		// restart clears the old counts
		do_start();
		repeat (3) pulse(corr_pkg::line_mask_t'($urandom_range(1, 15)));
		repeat (6) @(negedge intclk);
		do_start();
		repeat (4) pulse(corr_pkg::line_mask_t'($urandom_range(1, 15)));
		do_stop();

		repeat (4) @(negedge intclk);
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: compile.f
common/corr_pkg.sv
logic/line_conditioner.sv
correlator/pulse_counter.sv
correlator/coincidence_counter.sv
logic/cmd_parser.sv
logic/packet_tx.sv
logic/corr_top.sv
tb/tb_clock.sv
tb/corr_tb.sv

// File: Bender.yml
package:
  name: corr_core

sources:
  - common/corr_pkg.sv
  - logic/line_conditioner.sv
  - correlator/pulse_counter.sv
  - correlator/coincidence_counter.sv
  - logic/cmd_parser.sv
  - logic/packet_tx.sv
  - logic/corr_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/corr_tb.sv
